// ==== hw/isaPkg.sv ====
`default_nettype none

package isaPkg;

	// one full 9-bit instruction word
	typedef logic [8:0] instrT;

	// opcode field of R/SR and I formats, instr[7:5]
	typedef logic [2:0] opcodeT;

	// S-type table index, instr[7:1]
	typedef logic [6:0] sCodeT;

	// format select bits
	localparam int iTypeBit = 8;
	localparam int sTypeBit = 0;

	// R/SR-type opcodes
	localparam opcodeT opAdd   = 3'd0;
	localparam opcodeT opSub   = 3'd1;
	localparam opcodeT opXor   = 3'd2;
	localparam opcodeT opLoad  = 3'd3;
	localparam opcodeT opStore = 3'd4;
	localparam opcodeT opSll   = 3'd5;
	localparam opcodeT opSrl   = 3'd6;

	// I-type opcodes, anything else decodes as addi
	localparam opcodeT opAddi = 3'd0;
	localparam opcodeT opLi   = 3'd1;
	localparam opcodeT opLov  = 3'd2;
	localparam opcodeT opAndi = 3'd5;

	// S-type code that stops the machine
	localparam sCodeT sHalt = 7'd60;

endpackage

`default_nettype wire

// ==== hw/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	typedef enum logic [2:0] {
		kAdd = 3'd0,
		kSub,
		kXor,
		kAnd,
		kSll,
		kSrl
	} aluOpT;

	typedef logic [2:0] srcASelT;
	typedef logic [3:0] srcBSelT;
	typedef logic [3:0] memAddrSelT;
	typedef logic [3:0] memInSelT;

	// ALU operand A sources
	localparam srcASelT srcARs   = 3'd0;
	localparam srcASelT srcAAcc  = 3'd1;
	localparam srcASelT srcAZero = 3'd2;

	// ALU operand B sources, mostly fixed constants of the program
	localparam srcBSelT srcBRt          = 4'd0;
	localparam srcBSelT srcBShamt       = 4'd1;
	localparam srcBSelT srcBImm         = 4'd2;
	localparam srcBSelT srcBZero        = 4'd3;
	localparam srcBSelT srcBNine        = 4'd4;
	localparam srcBSelT srcBSpace       = 4'd5;
	localparam srcBSelT srcBEight       = 4'd6;
	localparam srcBSelT srcBFiftyFour   = 4'd7;
	localparam srcBSelT srcBByteMask    = 4'd8;
	localparam srcBSelT srcBOne         = 4'd9;
	localparam srcBSelT srcBFortyOne    = 4'd11;
	localparam srcBSelT srcBPatternBase = 4'd12;

	// memory address sources, key bytes sit at 6 through 13
	localparam memAddrSelT memAddrRs       = 4'd0;
	localparam memAddrSelT memAddrPattern  = 4'd1;
	localparam memAddrSelT memAddrSeed     = 4'd2;
	localparam memAddrSelT memAddrSpace    = 4'd5;
	localparam memAddrSelT memAddrKeyBase  = 4'd6;
	localparam memAddrSelT memAddrFortyOne = 4'd14;

	// memory write data sources, key bytes at 4 through 11
	localparam memInSelT memInRt      = 4'd0;
	localparam memInSelT memInSpace   = 4'd1;
	localparam memInSelT memInZero    = 4'd2;
	localparam memInSelT memInKeyBase = 4'd4;

	typedef struct packed {
		logic       writeReg;
		srcASelT    srcASel;
		srcBSelT    srcBSel;
		logic       regIn;
		memAddrSelT memAddrSel;
		memInSelT   memInSel;
		logic       memRead;
		logic       memWrite;
		aluOpT      aluOp;
	} ctrlT;

	typedef struct packed {
		logic halt;
		logic beq;
		logic bne;
		logic bgt;
	} flowT;

	localparam ctrlT ctrlNop  = '0;
	localparam flowT flowNone = '0;

	// ALU result written back to the register file
	function automatic ctrlT regWrite(srcASelT srcA, srcBSelT srcB, aluOpT op);
		ctrlT c;
		c = ctrlNop;
		c.writeReg = 1'b1;
		c.srcASel = srcA;
		c.srcBSel = srcB;
		c.aluOp = op;
		return c;
	endfunction

	// memory read data written back to the register file
	function automatic ctrlT memLoad(memAddrSelT addr);
		ctrlT c;
		c = ctrlNop;
		c.writeReg = 1'b1;
		c.regIn = 1'b1;
		c.memRead = 1'b1;
		c.memAddrSel = addr;
		return c;
	endfunction

	function automatic ctrlT memStore(memAddrSelT addr, memInSelT data);
		ctrlT c;
		c = ctrlNop;
		c.memWrite = 1'b1;
		c.memAddrSel = addr;
		c.memInSel = data;
		return c;
	endfunction

endpackage

`default_nettype wire

// ==== hw/rTypeDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rTypeDecoder
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  opcodeT opcode,
	output ctrlT   ctrl
);

	always_comb begin
		ctrl = ctrlNop;
		case (opcode)
			// register-register arithmetic
			opAdd: begin
				ctrl = regWrite(srcARs, srcBRt, kAdd);
			end
			opSub: begin
				ctrl = regWrite(srcARs, srcBRt, kSub);
			end
			opXor: begin
				ctrl = regWrite(srcARs, srcBRt, kXor);
			end

			// load byte, address comes from rs
			opLoad: begin
				ctrl = memLoad(memAddrRs);
			end

			// store byte, rt data to address in rs
			opStore: begin
				ctrl = memStore(memAddrRs, memInRt);
			end

			// shift left always by one
			opSll: begin
				ctrl = regWrite(srcARs, srcBOne, kSll);
			end

			// shift right by the shamt field
			opSrl: begin
				ctrl = regWrite(srcARs, srcBShamt, kSrl);
			end

			// opcode 7 is unassigned, treated as a plain add
			default: begin
				ctrl = regWrite(srcARs, srcBRt, kAdd);
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/iTypeDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module iTypeDecoder
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  opcodeT opcode,
	output ctrlT   ctrl
);

	always_comb begin
		ctrl = ctrlNop;
		case (opcode)
			opAddi: begin
				ctrl = regWrite(srcARs, srcBImm, kAdd);
			end

			// load immediate, zero plus imm
			opLi: begin
				ctrl = regWrite(srcAZero, srcBImm, kAdd);
			end

			// move rs through the ALU unchanged
			opLov: begin
				ctrl = regWrite(srcARs, srcBZero, kAdd);
			end

			opAndi: begin
				ctrl = regWrite(srcARs, srcBImm, kAnd);
			end

			// unassigned opcodes behave like addi
			default: begin
				ctrl = regWrite(srcARs, srcBImm, kAdd);
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/sTypeDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module sTypeDecoder
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  sCodeT code,
	output ctrlT  ctrl,
	output flowT  flow
);

	// branch compare with no write back
	function automatic ctrlT cmpCtrl(srcASelT srcA, srcBSelT srcB);
		ctrlT c;
		c = ctrlNop;
		c.srcASel = srcA;
		c.srcBSel = srcB;
		c.aluOp = kSub;
		return c;
	endfunction

	// fixed key byte n goes to key slot n
	function automatic ctrlT keyStore(logic [2:0] idx);
		return memStore(memAddrKeyBase + memAddrSelT'(idx), memInKeyBase + memInSelT'(idx));
	endfunction

	always_comb begin
		ctrl = ctrlNop;
		flow = flowNone;
		case (code)
			// init loads of pattern and seed
			7'd0: begin
				ctrl = memLoad(memAddrPattern);
			end
			7'd1: begin
				ctrl = memLoad(memAddrSeed);
			end

			// register clear that la also uses
			7'd2, 7'd3, 7'd34, 7'd35, 7'd39: begin
				ctrl = regWrite(srcAZero, srcBZero, kAdd);
			end

			// copy the accumulator
			7'd4, 7'd38: begin
				ctrl = regWrite(srcAAcc, srcBZero, kAdd);
			end

			7'd5: begin
				ctrl = memStore(memAddrSpace, memInSpace);
			end

			// space reload also selects space as write data
			7'd6: begin
				ctrl = memLoad(memAddrSpace);
				ctrl.memInSel = memInSpace;
			end

			// remaining length as acc minus rt
			7'd7: begin
				ctrl = regWrite(srcAAcc, srcBRt, kSub);
			end

			// masks
			7'd8, 7'd25: begin
				ctrl = regWrite(srcARs, srcBRt, kAnd);
			end
			7'd9, 7'd26: begin
				ctrl = regWrite(srcARs, srcBOne, kAnd);
			end
			7'd11: begin
				ctrl = regWrite(srcARs, srcBByteMask, kAnd);
			end

			// adds and xors on rs
			7'd10, 7'd27, 7'd43: begin
				ctrl = regWrite(srcARs, srcBRt, kAdd);
			end
			7'd12, 7'd29: begin
				ctrl = regWrite(srcARs, srcBRt, kXor);
			end
			7'd13: begin
				ctrl = regWrite(srcARs, srcBSpace, kXor);
			end

			// pointer and counter increments
			7'd31, 7'd32, 7'd41, 7'd42, 7'd61: begin
				ctrl = regWrite(srcARs, srcBOne, kAdd);
			end

			// move rt
			7'd45: begin
				ctrl = regWrite(srcAZero, srcBRt, kAdd);
			end
			7'd46: begin
				ctrl = regWrite(srcARs, srcBOne, kSll);
			end
			7'd55: begin
				ctrl = regWrite(srcAZero, srcBPatternBase, kAdd);
			end

			// lbu and sb through rs
			7'd28, 7'd40, 7'd44: begin
				ctrl = memLoad(memAddrRs);
			end
			7'd30: begin
				ctrl = memStore(memAddrRs, memInRt);
			end
			7'd33, 7'd36: begin
				ctrl = memStore(memAddrRs, memInZero);
			end

			// key bytes into 55..62
			7'd47: ctrl = keyStore(3'd0);
			7'd48: ctrl = keyStore(3'd1);
			7'd49: ctrl = keyStore(3'd2);
			7'd50: ctrl = keyStore(3'd3);
			7'd51: ctrl = keyStore(3'd4);
			7'd52: ctrl = keyStore(3'd5);
			7'd53: ctrl = keyStore(3'd6);
			7'd54: ctrl = keyStore(3'd7);

			// loads the constant 41 into r0
			7'd62: begin
				ctrl = memLoad(memAddrFortyOne);
				ctrl.srcASel = srcAZero;
				ctrl.srcBSel = srcBFortyOne;
			end

			// bne
			7'd14, 7'd22, 7'd56, 7'd57, 7'd58: begin
				ctrl = cmpCtrl(srcARs, srcBRt);
				flow.bne = 1'b1;
			end
			7'd21, 7'd23: begin
				ctrl = cmpCtrl(srcARs, srcBSpace);
				flow.bne = 1'b1;
			end
			7'd37: begin
				ctrl = cmpCtrl(srcARs, srcBFiftyFour);
				flow.bne = 1'b1;
			end

			// beq with zero against zero jumps unconditionally
			7'd15: begin
				ctrl = cmpCtrl(srcARs, srcBRt);
				flow.beq = 1'b1;
			end
			7'd16, 7'd17, 7'd19, 7'd59: begin
				ctrl = cmpCtrl(srcAZero, srcBZero);
				flow.beq = 1'b1;
			end
			7'd18: begin
				ctrl = cmpCtrl(srcARs, srcBZero);
				flow.beq = 1'b1;
			end
			7'd20: begin
				ctrl = cmpCtrl(srcARs, srcBNine);
				flow.beq = 1'b1;
			end

			// bgt
			7'd24: begin
				ctrl = cmpCtrl(srcARs, srcBEight);
				flow.bgt = 1'b1;
			end

			sHalt: begin
				flow.halt = 1'b1;
			end

			// undefined codes stay nop
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/controlDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlDecoder
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  instrT instr,
	output ctrlT  ctrl,
	output flowT  flow
);

	opcodeT opcode;
	sCodeT  sCode;
	ctrlT   rCtrl;
	ctrlT   iCtrl;
	ctrlT   sCtrl;
	flowT   sFlow;

	// R and I share the opcode field, S uses the whole middle
	assign opcode = instr[7:5];
	assign sCode = instr[7:1];

	rTypeDecoder i_rTypeDecoder (
		.opcode(opcode),
		.ctrl  (rCtrl)
	);

	iTypeDecoder i_iTypeDecoder (
		.opcode(opcode),
		.ctrl  (iCtrl)
	);

	sTypeDecoder i_sTypeDecoder (
		.code(sCode),
		.ctrl(sCtrl),
		.flow(sFlow)
	);

	// bit 8 wins over bit 0
	always_comb begin
		if (instr[iTypeBit]) begin
			ctrl = iCtrl;
			flow = flowNone;
		end else if (!instr[sTypeBit]) begin
			ctrl = rCtrl;
			flow = flowNone;
		end else begin
			ctrl = sCtrl;
			flow = sFlow;
		end
	end

endmodule

`default_nettype wire

// ==== bench/decodeVectors.svh ====
`ifndef decodeVectorsSvh
`define decodeVectorsSvh

localparam int numVectors = 60;

// each row holds test name, instruction, expected control word and expected flow flags
// ctrlWord flags are {writeReg, regIn, memRead, memWrite}, then srcA, srcB, addr, data, alu op
task automatic buildVectors();
	// every R/SR-type opcode
	addRow("add", rFormat(opAdd), ctrlWord(4'h8, srcARs, srcBRt, 4'h0, 4'h0, kAdd), flowNone);
	addRow("sub", rFormat(opSub), ctrlWord(4'h8, srcARs, srcBRt, 4'h0, 4'h0, kSub), flowNone);
	addRow("xor", rFormat(opXor), ctrlWord(4'h8, srcARs, srcBRt, 4'h0, 4'h0, kXor), flowNone);
	addRow("lw", rFormat(opLoad), ctrlWord(4'he, srcARs, srcBRt, 4'h0, 4'h0, kAdd), flowNone);
	addRow("sw", rFormat(opStore), ctrlWord(4'h1, srcARs, srcBRt, 4'h0, 4'h0, kAdd), flowNone);
	addRow("sll", rFormat(opSll), ctrlWord(4'h8, srcARs, srcBOne, 4'h0, 4'h0, kSll), flowNone);
	addRow("srl", rFormat(opSrl), ctrlWord(4'h8, srcARs, srcBShamt, 4'h0, 4'h0, kSrl), flowNone);
	addRow("r op7", rFormat(3'd7), ctrlWord(4'h8, srcARs, srcBRt, 4'h0, 4'h0, kAdd), flowNone);

	// each I-type opcode with bit 0 clear and with bit 0 set
	addITypeRows("addi", opAddi, ctrlWord(4'h8, srcARs, srcBImm, 4'h0, 4'h0, kAdd));
	addITypeRows("li", opLi, ctrlWord(4'h8, srcAZero, srcBImm, 4'h0, 4'h0, kAdd));
	addITypeRows("lov", opLov, ctrlWord(4'h8, srcARs, srcBZero, 4'h0, 4'h0, kAdd));
	addITypeRows("i op3", 3'd3, ctrlWord(4'h8, srcARs, srcBImm, 4'h0, 4'h0, kAdd));
	addITypeRows("i op4", 3'd4, ctrlWord(4'h8, srcARs, srcBImm, 4'h0, 4'h0, kAdd));
	addITypeRows("andi", opAndi, ctrlWord(4'h8, srcARs, srcBImm, 4'h0, 4'h0, kAnd));
	addITypeRows("i op6", 3'd6, ctrlWord(4'h8, srcARs, srcBImm, 4'h0, 4'h0, kAdd));
	addITypeRows("i op7", 3'd7, ctrlWord(4'h8, srcARs, srcBImm, 4'h0, 4'h0, kAdd));

	// S-type branches only compare
	addRow("bne14", sFormat(14), ctrlWord(4'h0, srcARs, srcBRt, 4'h0, 4'h0, kSub), bneFlow);
	addRow("beq15", sFormat(15), ctrlWord(4'h0, srcARs, srcBRt, 4'h0, 4'h0, kSub), beqFlow);
	addRow("beq16", sFormat(16), ctrlWord(4'h0, srcAZero, srcBZero, 4'h0, 4'h0, kSub), beqFlow);
	addRow("beq17", sFormat(17), ctrlWord(4'h0, srcAZero, srcBZero, 4'h0, 4'h0, kSub), beqFlow);
	addRow("beq18", sFormat(18), ctrlWord(4'h0, srcARs, srcBZero, 4'h0, 4'h0, kSub), beqFlow);
	addRow("beq19", sFormat(19), ctrlWord(4'h0, srcAZero, srcBZero, 4'h0, 4'h0, kSub), beqFlow);
	addRow("beq20", sFormat(20), ctrlWord(4'h0, srcARs, srcBNine, 4'h0, 4'h0, kSub), beqFlow);
	addRow("bne21", sFormat(21), ctrlWord(4'h0, srcARs, srcBSpace, 4'h0, 4'h0, kSub), bneFlow);
	addRow("bne22", sFormat(22), ctrlWord(4'h0, srcARs, srcBRt, 4'h0, 4'h0, kSub), bneFlow);
	addRow("bne23", sFormat(23), ctrlWord(4'h0, srcARs, srcBSpace, 4'h0, 4'h0, kSub), bneFlow);
	addRow("bgt24", sFormat(24), ctrlWord(4'h0, srcARs, srcBEight, 4'h0, 4'h0, kSub), bgtFlow);
	addRow("bne37", sFormat(37),
		ctrlWord(4'h0, srcARs, srcBFiftyFour, 4'h0, 4'h0, kSub), bneFlow);
	addRow("bne56", sFormat(56), ctrlWord(4'h0, srcARs, srcBRt, 4'h0, 4'h0, kSub), bneFlow);
	addRow("bne57", sFormat(57), ctrlWord(4'h0, srcARs, srcBRt, 4'h0, 4'h0, kSub), bneFlow);
	addRow("bne58", sFormat(58), ctrlWord(4'h0, srcARs, srcBRt, 4'h0, 4'h0, kSub), bneFlow);
	addRow("beq59", sFormat(59), ctrlWord(4'h0, srcAZero, srcBZero, 4'h0, 4'h0, kSub), beqFlow);

	// S-type memory entries
	addRow("init0", sFormat(0), ctrlWord(4'he, srcARs, srcBRt, 4'h1, 4'h0, kAdd), flowNone);
	addRow("init1", sFormat(1), ctrlWord(4'he, srcARs, srcBRt, 4'h2, 4'h0, kAdd), flowNone);
	addRow("space5", sFormat(5), ctrlWord(4'h1, srcARs, srcBRt, 4'h5, 4'h1, kAdd), flowNone);
	addRow("space6", sFormat(6), ctrlWord(4'he, srcARs, srcBRt, 4'h5, 4'h1, kAdd), flowNone);
	addRow("lbu28", sFormat(28), ctrlWord(4'he, srcARs, srcBRt, 4'h0, 4'h0, kAdd), flowNone);
	addRow("lbu40", sFormat(40), ctrlWord(4'he, srcARs, srcBRt, 4'h0, 4'h0, kAdd), flowNone);
	addRow("lbu44", sFormat(44), ctrlWord(4'he, srcARs, srcBRt, 4'h0, 4'h0, kAdd), flowNone);
	addRow("sb30", sFormat(30), ctrlWord(4'h1, srcARs, srcBRt, 4'h0, 4'h0, kAdd), flowNone);
	addRow("sb33", sFormat(33), ctrlWord(4'h1, srcARs, srcBRt, 4'h0, 4'h2, kAdd), flowNone);
	addRow("sb36", sFormat(36), ctrlWord(4'h1, srcARs, srcBRt, 4'h0, 4'h2, kAdd), flowNone);
	addRow("key0", sFormat(47), ctrlWord(4'h1, srcARs, srcBRt, 4'h6, 4'h4, kAdd), flowNone);
	addRow("key1", sFormat(48), ctrlWord(4'h1, srcARs, srcBRt, 4'h7, 4'h5, kAdd), flowNone);
	addRow("key2", sFormat(49), ctrlWord(4'h1, srcARs, srcBRt, 4'h8, 4'h6, kAdd), flowNone);
	addRow("key3", sFormat(50), ctrlWord(4'h1, srcARs, srcBRt, 4'h9, 4'h7, kAdd), flowNone);
	addRow("key4", sFormat(51), ctrlWord(4'h1, srcARs, srcBRt, 4'ha, 4'h8, kAdd), flowNone);
	addRow("key5", sFormat(52), ctrlWord(4'h1, srcARs, srcBRt, 4'hb, 4'h9, kAdd), flowNone);
	addRow("key6", sFormat(53), ctrlWord(4'h1, srcARs, srcBRt, 4'hc, 4'ha, kAdd), flowNone);
	addRow("key7", sFormat(54), ctrlWord(4'h1, srcARs, srcBRt, 4'hd, 4'hb, kAdd), flowNone);
	addRow("load41", sFormat(62),
		ctrlWord(4'he, srcAZero, srcBFortyOne, 4'he, 4'h0, kAdd), flowNone);

	// halt leaves the control word empty
	addRow("halt", sFormat(60), ctrlNop, haltFlow);
endtask

`endif

// ==== bench/controlDecoderTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlDecoderTb
	import isaPkg::*;
	import ctrlPkg::*;
();

	localparam int clkPeriod = 8;
	localparam int resetCycles = 3;
	localparam int randomCases = 64;

	// codes above the highest table entry decode as nop
	localparam sCodeT lastSCode = 7'd62;

	localparam flowT haltFlow = '{halt: 1'b1, default: 1'b0};
	localparam flowT beqFlow = '{beq: 1'b1, default: 1'b0};
	localparam flowT bneFlow = '{bne: 1'b1, default: 1'b0};
	localparam flowT bgtFlow = '{bgt: 1'b1, default: 1'b0};

	`include "decodeVectors.svh"

	localparam int timeoutNs = (numVectors + randomCases + resetCycles + 10) * clkPeriod;

	logic clk = 1'b0;
	logic rstN;
	instrT instr;
	ctrlT ctrl;
	flowT flow;

	string names[numVectors];
	instrT instrs[numVectors];
	ctrlT ctrls[numVectors];
	flowT flows[numVectors];
	int rowCount = 0;

	int ctrlErrors = 0;
	int flowErrors = 0;
	int otherErrors = 0;
	integer seed;

	controlDecoder i_dut (
		.instr(instr),
		.ctrl (ctrl),
		.flow (flow)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// bits 4:1 carry a pattern the R decode must ignore
	function automatic instrT rFormat(opcodeT op);
		return {1'b0, op, 4'b0110, 1'b0};
	endfunction

	function automatic instrT iFormat(opcodeT op, logic lsb);
		return {1'b1, op, 4'b1001, lsb};
	endfunction

	function automatic instrT sFormat(int code);
		sCodeT c;
		c = sCodeT'(code);
		return {1'b0, c, 1'b1};
	endfunction

	function automatic ctrlT ctrlWord(logic [3:0] flags, srcASelT a, srcBSelT b,
			memAddrSelT addr, memInSelT din, aluOpT op);
		ctrlT c;
		c.writeReg = flags[3];
		c.regIn = flags[2];
		c.memRead = flags[1];
		c.memWrite = flags[0];
		c.srcASel = a;
		c.srcBSel = b;
		c.memAddrSel = addr;
		c.memInSel = din;
		c.aluOp = op;
		return c;
	endfunction

	task automatic addRow(string name, instrT ins, ctrlT c, flowT f);
		if (rowCount < numVectors) begin
			names[rowCount] = name;
			instrs[rowCount] = ins;
			ctrls[rowCount] = c;
			flows[rowCount] = f;
		end
		rowCount++;
	endtask

	// bit 0 set must not turn an I-type into S-type
	task automatic addITypeRows(string name, opcodeT op, ctrlT c);
		addRow(name, iFormat(op, 1'b0), c, flowNone);
		addRow({name, " bit0"}, iFormat(op, 1'b1), c, flowNone);
	endtask

	task automatic checkCtrl(string name, ctrlT expected, ctrlT actual);
		if (actual !== expected) begin
			ctrlErrors++;
			$display("error %s: ctrl expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkFlow(string name, flowT expected, flowT actual);
		if (actual !== expected) begin
			flowErrors++;
			$display("error %s: flow expected %b, actual %b", name, expected, actual);
		end
	endtask

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

	initial begin
		integer r;
		sCodeT code;
		instr = '0;
		seed = 32'hbccd_2938;
		buildVectors();
		if (rowCount != numVectors) begin
			otherErrors++;
			$display("vector table holds %0d rows instead of %0d", rowCount, numVectors);
		end
		wait (rstN === 1'b1);

		for (int i = 0; i < numVectors; i++) begin
			@(negedge clk);
			instr = instrs[i];
			@(posedge clk);
			checkCtrl(names[i], ctrls[i], ctrl);
			checkFlow(names[i], flows[i], flow);
		end

		// undefined S-type codes only
		for (int i = 0; i < randomCases; i++) begin
			r = $random(seed);
			code = r[6:0];
			if (code <= lastSCode) begin
				code[6] = 1'b1;
			end
			@(negedge clk);
			instr = {1'b0, code, 1'b1};
			@(posedge clk);
			checkCtrl($sformatf("random s code %0d", code), ctrlNop, ctrl);
			checkFlow($sformatf("random s code %0d", code), flowNone, flow);
		end

		@(negedge clk);
		$display("errors: ctrl %0d, flow %0d, other %0d", ctrlErrors, flowErrors, otherErrors);
		if (ctrlErrors + flowErrors + otherErrors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(timeoutNs);
		$display("timeout: decoder checks still running after %0d ns", timeoutNs);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+bench
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/rTypeDecoder.sv
hw/iTypeDecoder.sv
hw/sTypeDecoder.sv
hw/controlDecoder.sv
bench/controlDecoderTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= controlDecoderTb
BUILD_DIR ?= obj_dir
FLIST ?= flist.f
VFLAGS ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_TEXT ?= Result: PASSED

SOURCES := $(filter-out +%,$(shell cat $(FLIST)))
HEADERS := $(wildcard bench/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FLIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; status=$$?; echo "$$out"; \
	[ $$status -eq 0 ] && echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
